// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_core
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hw/rv_control.sv ====
module rv_control (
    input  rv_pkg::instr_u instr,
    output rv_pkg::ctrl_t  ctrl,
    output rv_pkg::word_t  imm
);

    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;

    function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] funct3,
                                                        input logic alt);
        case (funct3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (instr.r.opcode)
            rv_pkg::OP_LUI: begin
                ctrl.reg_wr = 1'b1;
                ctrl.bsrc   = rv_pkg::BSRC_IMM;
                ctrl.alu_op = rv_pkg::ALU_PASS_B;
                imm         = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                ctrl.reg_wr = 1'b1;
                ctrl.asrc   = rv_pkg::ASRC_PC;
                ctrl.bsrc   = rv_pkg::BSRC_IMM;
                imm         = imm_u;
            end
            rv_pkg::OP_JAL, rv_pkg::OP_JALR: begin
                ctrl.reg_wr = 1'b1;
                ctrl.asrc   = rv_pkg::ASRC_PC;   // Link is pc + 4.
                ctrl.bsrc   = rv_pkg::BSRC_FOUR;
                ctrl.branch = instr.r.opcode[3] ? rv_pkg::BR_JAL : rv_pkg::BR_JALR;
                imm         = instr.r.opcode[3] ? imm_j : imm_i;
            end
            rv_pkg::OP_BRANCH: begin
                if (instr.r.funct3[2]) begin
                    ctrl.branch = instr.r.funct3[0] ? rv_pkg::BR_GE : rv_pkg::BR_LT;
                end else begin
                    ctrl.branch = instr.r.funct3[0] ? rv_pkg::BR_NE : rv_pkg::BR_EQ;
                end
                ctrl.alu_op = instr.r.funct3[1] ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SLT;
                imm         = imm_b;
            end
            rv_pkg::OP_LOAD: begin
                ctrl.reg_wr     = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_op     = instr.r.funct3;
                ctrl.bsrc       = rv_pkg::BSRC_IMM;
                imm             = imm_i;
            end
            rv_pkg::OP_STORE: begin
                ctrl.mem_wr = 1'b1;
                ctrl.mem_op = instr.r.funct3;
                ctrl.bsrc   = rv_pkg::BSRC_IMM;
                imm         = imm_s;
            end
            rv_pkg::OP_IMM: begin
                ctrl.reg_wr = 1'b1;
                ctrl.bsrc   = rv_pkg::BSRC_IMM;
                ctrl.alu_op = alu_from_funct3(instr.r.funct3,
                                  instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
                imm         = imm_i;
            end
            rv_pkg::OP_REG: begin
                ctrl.reg_wr = 1'b1;
                ctrl.alu_op = alu_from_funct3(instr.r.funct3, instr.r.funct7[5]);
            end
            default: ;   // SYSTEM, FENCE and unknown words.
        endcase
    end

endmodule

// ==== hw/rv_core.sv ====
module rv_core (
    input  logic          clk,
    input  logic          arst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    input  rv_pkg::word_t dmem_rdata,
    output logic [2:0]    dmem_op,
    output logic          dmem_we
);

    rv_pkg::word_t      if_pc;
    rv_pkg::word_t      redirect_pc;
    rv_pkg::word_t      mem_result;
    rv_pkg::instr_u     if_instr;
    rv_pkg::id_ex_t     id_ex;
    rv_pkg::ex_mem_t    ex_mem;
    rv_pkg::mem_wb_t    mem_wb;
    rv_pkg::fwd_e       fwd_a;
    rv_pkg::fwd_e       fwd_b;
    rv_pkg::stage_ctl_t pc_ctl;
    rv_pkg::stage_ctl_t ifid_ctl;
    rv_pkg::stage_ctl_t idex_ctl;
    rv_pkg::stage_ctl_t exmem_ctl;
    logic               redirect;

    rv_fetch fetch_inst (
        .clk(clk), .arst_n(arst_n), .pc_ctl(pc_ctl), .ifid_ctl(ifid_ctl),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .if_pc(if_pc), .if_instr(if_instr)
    );

    rv_decode decode_inst (
        .clk(clk), .arst_n(arst_n), .if_pc(if_pc), .if_instr(if_instr),
        .wb(mem_wb), .idex_ctl(idex_ctl), .id_ex(id_ex)
    );

    rv_execute execute_inst (
        .clk(clk), .arst_n(arst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_result(mem_result), .wb_result(mem_wb.result),
        .exmem_ctl(exmem_ctl), .ex_mem(ex_mem)
    );

    rv_memory memory_inst (
        .clk(clk), .arst_n(arst_n), .ex_mem(ex_mem),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_op(dmem_op),
        .dmem_we(dmem_we), .dmem_rdata(dmem_rdata),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_result(mem_result), .mem_wb(mem_wb)
    );

    rv_hazard hazard_inst (
        .ifid_rs1(if_instr.r.rs1), .ifid_rs2(if_instr.r.rs2),
        .idex_rs1(id_ex.rs1), .idex_rs2(id_ex.rs2), .idex_rd(id_ex.rd),
        .idex_mem_to_reg(id_ex.ctrl.mem_to_reg), .idex_reg_wr(id_ex.ctrl.reg_wr),
        .exmem_rd(ex_mem.rd), .exmem_reg_wr(ex_mem.ctrl.reg_wr),
        .wb_rd(mem_wb.rd), .wb_reg_wr(mem_wb.reg_wr),
        .clk(clk), .arst_n(arst_n), .redirect(redirect),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .pc_ctl(pc_ctl), .ifid_ctl(ifid_ctl), .idex_ctl(idex_ctl), .exmem_ctl(exmem_ctl)
    );

endmodule

// ==== hw/rv_decode.sv ====
module rv_decode (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_pkg::word_t      if_pc,
    input  rv_pkg::instr_u     if_instr,
    input  rv_pkg::mem_wb_t    wb,
    input  rv_pkg::stage_ctl_t idex_ctl,
    output rv_pkg::id_ex_t     id_ex
);

    rv_pkg::ctrl_t  ctrl;
    rv_pkg::word_t  imm;
    rv_pkg::word_t  rs1_data;
    rv_pkg::word_t  rs2_data;
    rv_pkg::id_ex_t id_next;

    rv_control control_inst (
        .instr(if_instr),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rv_regfile regfile_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_addr(if_instr.r.rs1),
        .rs2_addr(if_instr.r.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb      (wb)
    );

    always_comb begin
        id_next.pc      = if_pc;
        id_next.imm     = imm;
        id_next.rs1_val = rs1_data;
        id_next.rs2_val = rs2_data;
        id_next.rs1     = if_instr.r.rs1;
        id_next.rs2     = if_instr.r.rs2;
        id_next.rd      = if_instr.r.rd;
        id_next.ctrl    = ctrl;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (idex_ctl.flush) begin
            id_ex <= '0;
        end else if (!idex_ctl.hold) begin
            id_ex <= id_next;
        end
    end

endmodule

// ==== hw/rv_execute.sv ====
module rv_execute (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_pkg::id_ex_t     id_ex,
    input  rv_pkg::fwd_e       fwd_a,
    input  rv_pkg::fwd_e       fwd_b,
    input  rv_pkg::word_t      mem_result,
    input  rv_pkg::word_t      wb_result,
    input  rv_pkg::stage_ctl_t exmem_ctl,
    output rv_pkg::ex_mem_t    ex_mem
);

    rv_pkg::word_t   rs1_val;
    rv_pkg::word_t   rs2_val;
    rv_pkg::word_t   op_a;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   alu;
    logic            less_s;
    logic            less_u;
    rv_pkg::ex_mem_t ex_next;

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_e sel,
                                              input rv_pkg::word_t reg_val,
                                              input rv_pkg::word_t mem_val,
                                              input rv_pkg::word_t wb_val);
        case (sel)
            rv_pkg::FWD_MEM: return mem_val;
            rv_pkg::FWD_WB:  return wb_val;
            default:         return reg_val;
        endcase
    endfunction

    assign rs1_val = fwd_mux(fwd_a, id_ex.rs1_val, mem_result, wb_result);
    assign rs2_val = fwd_mux(fwd_b, id_ex.rs2_val, mem_result, wb_result);
    assign op_a    = (id_ex.ctrl.asrc == rv_pkg::ASRC_PC) ? id_ex.pc : rs1_val;

    always_comb begin
        case (id_ex.ctrl.bsrc)
            rv_pkg::BSRC_IMM:  op_b = id_ex.imm;
            rv_pkg::BSRC_FOUR: op_b = 32'd4;
            default:           op_b = rs2_val;
        endcase
    end

    // Branches compare rs1 against rs2 through these.
    assign less_s = $signed(op_a) < $signed(op_b);
    assign less_u = op_a < op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_pkg::ALU_SUB:  alu = op_a - op_b;
            rv_pkg::ALU_SLL:  alu = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:  alu = {{(rv_pkg::XLEN-1){1'b0}}, less_s};
            rv_pkg::ALU_SLTU: alu = {{(rv_pkg::XLEN-1){1'b0}}, less_u};
            rv_pkg::ALU_XOR:  alu = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu = rv_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            rv_pkg::ALU_OR:   alu = op_a | op_b;
            rv_pkg::ALU_AND:  alu = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu = op_b;
            default:          alu = op_a + op_b;
        endcase
    end

    always_comb begin
        ex_next.alu        = alu;
        ex_next.rs2_val    = rs2_val;     // Store data.
        ex_next.pc_target  = id_ex.pc + id_ex.imm;
        ex_next.rs1_target = rs1_val + id_ex.imm;
        ex_next.less       = (id_ex.ctrl.alu_op == rv_pkg::ALU_SLTU) ? less_u : less_s;
        ex_next.zero       = op_a == op_b;
        ex_next.rd         = id_ex.rd;
        ex_next.ctrl       = id_ex.ctrl;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (exmem_ctl.flush) begin
            ex_mem <= '0;
        end else if (!exmem_ctl.hold) begin
            ex_mem <= ex_next;
        end
    end

endmodule

// ==== hw/rv_fetch.sv ====
module rv_fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_pkg::stage_ctl_t pc_ctl,
    input  rv_pkg::stage_ctl_t ifid_ctl,
    input  logic               redirect,
    input  rv_pkg::word_t      redirect_pc,
    output rv_pkg::word_t      imem_addr,
    input  rv_pkg::word_t      imem_data,
    output rv_pkg::word_t      if_pc,
    output rv_pkg::instr_u     if_instr
);

    rv_pkg::word_t pc;

    assign imem_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_ctl.flush || !pc_ctl.hold) begin
            pc <= redirect ? redirect_pc : pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_pc    <= '0;
            if_instr <= '0;
        end else if (ifid_ctl.flush) begin
            if_instr <= '0;   // All-zero word decodes as a bubble.
        end else if (!ifid_ctl.hold) begin
            if_pc    <= pc;
            if_instr <= imem_data;
        end
    end

    // A redirect lands on an aligned target at the next fetch.
    a_redirect_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> imem_addr == $past(redirect_pc) && imem_addr[1:0] == 2'b00);

endmodule

// ==== hw/rv_hazard.sv ====
module rv_hazard (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_pkg::reg_addr_t  ifid_rs1,
    input  rv_pkg::reg_addr_t  ifid_rs2,
    input  rv_pkg::reg_addr_t  idex_rs1,
    input  rv_pkg::reg_addr_t  idex_rs2,
    input  rv_pkg::reg_addr_t  idex_rd,
    input  logic               idex_mem_to_reg,
    input  logic               idex_reg_wr,
    input  rv_pkg::reg_addr_t  exmem_rd,
    input  logic               exmem_reg_wr,
    input  rv_pkg::reg_addr_t  wb_rd,
    input  logic               wb_reg_wr,
    input  logic               redirect,
    output rv_pkg::fwd_e       fwd_a,
    output rv_pkg::fwd_e       fwd_b,
    output rv_pkg::stage_ctl_t pc_ctl,
    output rv_pkg::stage_ctl_t ifid_ctl,
    output rv_pkg::stage_ctl_t idex_ctl,
    output rv_pkg::stage_ctl_t exmem_ctl
);

    logic load_use;

    // MEM wins over WB, x0 is never forwarded.
    function automatic rv_pkg::fwd_e fwd_sel(input rv_pkg::reg_addr_t src);
        if (src == '0) begin
            return rv_pkg::FWD_NONE;
        end
        if (exmem_reg_wr && exmem_rd == src) begin
            return rv_pkg::FWD_MEM;
        end
        if (wb_reg_wr && wb_rd == src) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = fwd_sel(idex_rs1);
        fwd_b = fwd_sel(idex_rs2);
    end

    assign load_use = idex_mem_to_reg && idex_reg_wr && idex_rd != '0 &&
                      (idex_rd == ifid_rs1 || idex_rd == ifid_rs2);

    assign pc_ctl    = '{flush: redirect, hold: load_use};
    assign ifid_ctl  = '{flush: redirect, hold: load_use};
    assign idex_ctl  = '{flush: redirect || load_use, hold: 1'b0};
    assign exmem_ctl = '{flush: redirect, hold: 1'b0};

    // The bubble inserted by a stall cannot stall again.
    a_single_stall: assert property (@(posedge clk) disable iff (!arst_n)
        load_use |=> !load_use);

endmodule

// ==== hw/rv_memory.sv ====
module rv_memory (
    input  logic            clk,
    input  logic            arst_n,
    input  rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::word_t   dmem_addr,
    output rv_pkg::word_t   dmem_wdata,
    output logic [2:0]      dmem_op,
    output logic            dmem_we,
    input  rv_pkg::word_t   dmem_rdata,
    output logic            redirect,
    output rv_pkg::word_t   redirect_pc,
    output rv_pkg::word_t   mem_result,
    output rv_pkg::mem_wb_t mem_wb
);

    assign dmem_addr  = ex_mem.alu;
    assign dmem_wdata = ex_mem.rs2_val;
    assign dmem_op    = ex_mem.ctrl.mem_op;
    assign dmem_we    = ex_mem.ctrl.mem_wr;

    always_comb begin
        case (ex_mem.ctrl.branch)
            rv_pkg::BR_JAL, rv_pkg::BR_JALR: redirect = 1'b1;
            rv_pkg::BR_EQ: redirect = ex_mem.zero;
            rv_pkg::BR_NE: redirect = !ex_mem.zero;
            rv_pkg::BR_LT: redirect = ex_mem.less;
            rv_pkg::BR_GE: redirect = !ex_mem.less;
            default:       redirect = 1'b0;
        endcase
    end

    assign redirect_pc = (ex_mem.ctrl.branch == rv_pkg::BR_JALR) ?
                         {ex_mem.rs1_target[31:1], 1'b0} : ex_mem.pc_target;

    assign mem_result = ex_mem.ctrl.mem_to_reg ? dmem_rdata : ex_mem.alu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.result <= mem_result;
            mem_wb.rd     <= ex_mem.rd;
            mem_wb.reg_wr <= ex_mem.ctrl.reg_wr;
        end
    end

    // The slot behind a redirect was flushed to a bubble.
    a_bubble_after_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> !redirect && !dmem_we);

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // BLTU and BGEU use LT and GE with ALU_SLTU selecting the unsigned compare.
    typedef enum logic [2:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE
    } branch_e;

    typedef enum logic {ASRC_RS1, ASRC_PC} asrc_e;
    typedef enum logic [1:0] {BSRC_RS2, BSRC_IMM, BSRC_FOUR} bsrc_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [19:0] rest;
    } i_type_t;

    typedef struct packed {
        logic [6:0]  imm_11_5;
        logic [12:0] regs_funct3;
        logic [4:0]  imm_4_0;
        logic [6:0]  opcode;
    } s_type_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [12:0] regs_funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [11:0] rest;
    } u_type_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [11:0] rest;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

    typedef struct packed {
        logic       reg_wr;
        logic       mem_to_reg;
        logic       mem_wr;
        logic [2:0] mem_op;   // funct3 of the load or store.
        asrc_e      asrc;
        bsrc_e      bsrc;
        alu_op_e    alu_op;
        branch_e    branch;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     alu;
        word_t     rs2_val;
        word_t     pc_target;
        word_t     rs1_target;
        logic      less;
        logic      zero;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      reg_wr;
    } mem_wb_t;

    typedef struct packed {
        logic flush;
        logic hold;
    } stage_ctl_t;

endpackage

// ==== hw/rv_regfile.sv ====
module rv_regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  rv_pkg::mem_wb_t   wb
);

    rv_pkg::word_t regs [1:31];

    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.reg_wr && wb.rd == addr) begin
            return wb.result;   // Same-cycle write passes through.
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wb.reg_wr && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // A write reads back a cycle later, and one aimed at x0 leaves it at zero.
    a_write_reads_back: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(wb.reg_wr) && rs1_addr == $past(wb.rd) && !(wb.reg_wr && wb.rd == rs1_addr))
        |-> rs1_data == ((rs1_addr == '0) ? '0 : $past(wb.result)));

endmodule

// ==== test/tb_checker.sv ====
module tb_checker (
    input  logic          clk,
    input  logic          arst_n,
    input  rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t dmem_addr,
    input  rv_pkg::word_t dmem_wdata,
    input  logic [2:0]    dmem_op,
    input  logic          dmem_we,
    input  logic          finish_check,
    output logic          done,
    output int            errors
);

    localparam int N_STORES = 18;
    localparam int PARK_PC  = 236;

    typedef struct packed {
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
        logic [2:0]    op;
    } store_t;

    store_t exp_tab [N_STORES];
    int     idx;

    initial begin
        exp_tab[0]  = '{addr: 32'd0,  data: 32'd170,        op: 3'b010};
        exp_tab[1]  = '{addr: 32'd4,  data: 32'hFFFF_FFE7,  op: 3'b010};
        exp_tab[2]  = '{addr: 32'd8,  data: 32'h0000_000F,  op: 3'b010};
        exp_tab[3]  = '{addr: 32'd12, data: 32'd1,          op: 3'b010};
        exp_tab[4]  = '{addr: 32'd16, data: 32'd0,          op: 3'b010};
        exp_tab[5]  = '{addr: 32'd20, data: 32'hFFFF_FDAC,  op: 3'b010};
        exp_tab[6]  = '{addr: 32'd24, data: 32'h0000_0020,  op: 3'b010};
        exp_tab[7]  = '{addr: 32'd28, data: 32'd560,        op: 3'b010};
        exp_tab[8]  = '{addr: 32'd32, data: 32'hFFFF_FF9C,  op: 3'b010};
        exp_tab[9]  = '{addr: 32'd36, data: 32'h0000_01CC,  op: 3'b010};  // -100 + 560.
        exp_tab[10] = '{addr: 32'd40, data: 32'd100,        op: 3'b010};
        exp_tab[11] = '{addr: 32'd44, data: 32'd70,         op: 3'b010};
        exp_tab[12] = '{addr: 32'd48, data: 32'd168,        op: 3'b010};  // JAL link.
        exp_tab[13] = '{addr: 32'd52, data: 32'd192,        op: 3'b010};  // JALR link.
        exp_tab[14] = '{addr: 32'd56, data: 32'h1234_5000,  op: 3'b010};
        exp_tab[15] = '{addr: 32'd60, data: 32'h0000_10D8,  op: 3'b010};
        exp_tab[16] = '{addr: 32'd65, data: 32'hFFFF_FDAC,  op: 3'b000};
        exp_tab[17] = '{addr: 32'd70, data: 32'd560,        op: 3'b001};
    end

    initial begin
        idx    = 0;
        errors = 0;
    end

    assign done = idx >= N_STORES;

    // Sampled mid-cycle where the store port is settled.
    always @(negedge clk) begin
        if (arst_n && dmem_we) begin
            if (idx < N_STORES) begin
                if (dmem_addr !== exp_tab[idx].addr) begin
                    $display("Fail %0t dmem_addr expected %h got %h",
                             $time, exp_tab[idx].addr, dmem_addr);
                    errors++;
                end
                if (dmem_wdata !== exp_tab[idx].data) begin
                    $display("Fail %0t dmem_wdata expected %h got %h",
                             $time, exp_tab[idx].data, dmem_wdata);
                    errors++;
                end
                if (dmem_op !== exp_tab[idx].op) begin
                    $display("Fail %0t dmem_op expected %h got %h",
                             $time, exp_tab[idx].op, dmem_op);
                    errors++;
                end
                idx++;
            end else begin
                $display("Store at time %0t to address %h was not expected.", $time, dmem_addr);
                errors++;
            end
        end
    end

    // The parking JAL is followed by three fetches before it redirects.
    always @(negedge clk) begin
        if (arst_n && (imem_addr[1:0] != 2'b00 || imem_addr > PARK_PC + 12)) begin
            $display("Fetch from address %h at time %0t is outside the program.",
                     imem_addr, $time);
            errors++;
        end
    end

    always @(posedge finish_check) begin
        if (idx < N_STORES) begin
            $display("Only %0d of %0d expected stores were seen.", idx, N_STORES);
            errors++;
        end
    end

endmodule

// ==== test/tb_core.sv ====
module tb_core;

    localparam int PROG_LEN       = 60;
    localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 20;

    logic          clk;
    logic          arst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    rv_pkg::word_t dmem_rdata;
    logic [2:0]    dmem_op;
    logic          dmem_we;
    logic          finish_check;
    logic          done;
    int            errors;

    rv_pkg::word_t prog [PROG_LEN];
    rv_pkg::word_t dmem [64];

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t enc_i(input int imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_s(input int imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        logic [31:0] v;
        v = imm;
        return {v[11:5], rs2, rs1, f3, v[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t enc_b(input int imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_j(input int imm, input logic [4:0] rd);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
    endfunction

    rv_core rv_core_inst (
        .clk(clk), .arst_n(arst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .dmem_op(dmem_op), .dmem_we(dmem_we)
    );

    tb_checker checker_inst (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_op(dmem_op),
        .dmem_we(dmem_we), .finish_check(finish_check),
        .done(done), .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        // ALU chain, each step feeding the next.
        prog[0]  = enc_i(100, 0, 3'b000, 1, 7'b0010011);
        prog[1]  = enc_i(-30, 1, 3'b000, 2, 7'b0010011);
        prog[2]  = enc_r(7'h00, 2, 1, 3'b000, 3);
        prog[3]  = enc_r(7'h20, 1, 3, 3'b000, 4);
        prog[4]  = enc_i(3, 4, 3'b001, 5, 7'b0010011);
        prog[5]  = enc_r(7'h20, 3, 2, 3'b000, 6);
        prog[6]  = enc_i(12'h402, 6, 3'b101, 7, 7'b0010011);
        prog[7]  = enc_i(28, 6, 3'b101, 8, 7'b0010011);
        prog[8]  = enc_r(7'h00, 1, 6, 3'b010, 9);
        prog[9]  = enc_r(7'h00, 1, 6, 3'b011, 10);
        prog[10] = enc_r(7'h00, 6, 5, 3'b100, 11);
        prog[11] = enc_r(7'h00, 8, 11, 3'b110, 12);
        prog[12] = enc_r(7'h00, 5, 12, 3'b111, 13);
        prog[13] = enc_s(0, 3, 0, 3'b010);
        prog[14] = enc_s(4, 7, 0, 3'b010);
        prog[15] = enc_s(8, 8, 0, 3'b010);
        prog[16] = enc_s(12, 9, 0, 3'b010);
        prog[17] = enc_s(16, 10, 0, 3'b010);
        prog[18] = enc_s(20, 11, 0, 3'b010);
        prog[19] = enc_s(24, 13, 0, 3'b010);
        prog[20] = enc_s(28, 5, 0, 3'b010);
        // Load followed by a dependent add.
        prog[21] = enc_s(32, 6, 0, 3'b010);
        prog[22] = enc_i(32, 0, 3'b010, 14, 7'b0000011);
        prog[23] = enc_r(7'h00, 5, 14, 3'b000, 15);
        prog[24] = enc_s(36, 15, 0, 3'b010);
        // Branches. Stores in the shadow of a taken branch must vanish.
        prog[25] = enc_b(16, 4, 2, 3'b000);
        prog[26] = enc_s(40, 1, 0, 3'b010);
        prog[27] = enc_s(44, 1, 0, 3'b010);
        prog[28] = enc_s(48, 1, 0, 3'b010);
        prog[29] = enc_b(16, 4, 2, 3'b001);
        prog[30] = enc_s(40, 1, 0, 3'b010);
        prog[31] = enc_b(16, 1, 6, 3'b100);
        prog[32] = enc_s(44, 2, 0, 3'b010);
        prog[33] = enc_s(44, 2, 0, 3'b010);
        prog[34] = enc_s(44, 2, 0, 3'b010);
        prog[35] = enc_b(16, 1, 6, 3'b111);
        prog[36] = enc_s(48, 3, 0, 3'b010);
        prog[37] = enc_s(48, 3, 0, 3'b010);
        prog[38] = enc_s(48, 3, 0, 3'b010);
        prog[39] = enc_b(8, 6, 1, 3'b100);
        prog[40] = enc_s(44, 2, 0, 3'b010);
        // Jumps with links.
        prog[41] = enc_j(16, 16);
        prog[42] = enc_s(48, 1, 0, 3'b010);
        prog[43] = enc_s(48, 1, 0, 3'b010);
        prog[44] = enc_s(48, 1, 0, 3'b010);
        prog[45] = enc_s(48, 16, 0, 3'b010);
        prog[46] = enc_i(204, 0, 3'b000, 17, 7'b0010011);
        prog[47] = enc_i(4, 17, 3'b000, 18, 7'b1100111);
        prog[48] = enc_s(52, 1, 0, 3'b010);
        prog[49] = enc_s(52, 1, 0, 3'b010);
        prog[50] = enc_s(52, 1, 0, 3'b010);
        prog[51] = enc_s(52, 1, 0, 3'b010);
        prog[52] = enc_s(52, 18, 0, 3'b010);
        // Upper immediates, then byte and halfword stores.
        prog[53] = enc_u(20'h12345, 19, 7'b0110111);
        prog[54] = enc_u(20'h00001, 20, 7'b0010111);
        prog[55] = enc_s(56, 19, 0, 3'b010);
        prog[56] = enc_s(60, 20, 0, 3'b010);
        prog[57] = enc_s(65, 11, 0, 3'b000);
        prog[58] = enc_s(70, 5, 0, 3'b001);
        prog[59] = enc_j(0, 0);   // Park here.
    end

    // Memories answer a fixed delay after the edge.
    initial begin
        imem_data  = '0;
        dmem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (imem_addr[31:2] < PROG_LEN) begin
                imem_data = prog[imem_addr[31:2]];
            end else begin
                imem_data = 32'h0000_0013;
            end
            dmem_rdata = dmem[dmem_addr[7:2]];
        end
    end

    always @(posedge clk) begin
        if (dmem_we) begin
            case (dmem_op[1:0])
                2'b00: dmem[dmem_addr[7:2]][8*dmem_addr[1:0] +: 8] <= dmem_wdata[7:0];
                2'b01: dmem[dmem_addr[7:2]][16*dmem_addr[1] +: 16] <= dmem_wdata[15:0];
                default: dmem[dmem_addr[7:2]] <= dmem_wdata;
            endcase
        end
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hA500_0000 ^ (i * 32'h0001_0203);
        end
        arst_n       = 1'b0;
        finish_check = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        wait (done);
        repeat (10) @(posedge clk);   // Catch any stray store.
        finish_check = 1'b1;
        #1;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, not all stores were seen.", TIMEOUT_CYCLES);
        finish_check = 1'b1;
        #1;
        $display("Errors: %0d", errors + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/rv_pkg.sv
hw/rv_control.sv
hw/rv_regfile.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memory.sv
hw/rv_hazard.sv
hw/rv_core.sv
test/tb_checker.sv
test/tb_core.sv
